// File: bench/busSubsystemTb.sv
// Needs hw on the include path; memory is filled with full words before any random read
`include "addrMap_macros.svh"

module busSubsystemTb import busPkg::*, timerPkg::*; ();

    localparam wordT T0_BASE = `PERIPH_BASE + `TIMER0_OFFSET;
    localparam wordT T1_BASE = `PERIPH_BASE + `TIMER1_OFFSET;

    logic   clk;
    logic   arstN;
    wordT   addr;
    wordT   wData;
    byteEnT we;
    logic   extInt;
    wordT   rData;
    hwIntT  hwInt;

    wordT   shadow [`DATA_WORDS];
    wordT   lcgState;
    int     errorCount;
    int     checkCount;

    busSubsystem UUT (
        .clk(clk), .arstN(arstN), .addr(addr), .wData(wData), .we(we),
        .extInt(extInt), .rData(rData), .hwInt(hwInt)
    );

    always #20 clk = ~clk;

    function automatic wordT nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Data range reads the shadow and all else outside the timers reads zero
    function automatic wordT expectedRead(wordT a);
        if (a <= `DATA_END) begin
            return shadow[a[11:2]];
        end
        return '0;
    endfunction

    function automatic wordT mergeLanes(wordT old, wordT data, byteEnT be);
        wordT res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic wordT ctrlWord(logic en, timerModeE mode, logic mask);
        return {28'd0, mask, mode, en};
    endfunction

    task automatic checkWord(string name, wordT expected, wordT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s expected 0x%08h actual 0x%08h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic checkInt(string name, hwIntT expected, hwIntT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s expected 0x%02h actual 0x%02h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic writeWord(wordT a, wordT d, byteEnT be);
        @(negedge clk);
        addr  = a;
        wData = d;
        we    = be;
        @(negedge clk);
        we = '0;
    endtask

    task automatic readCheck(wordT a, wordT expected);
        @(negedge clk);
        addr = a;
        #5;
        checkWord("rData", expected, rData);
    endtask

    // Edges counted after the write that started the timer
    task automatic waitIrq(int irqBit, int limit, output int edges);
        int cyc;
        edges = 0;
        cyc   = 0;
        while (edges == 0 && cyc < limit) begin
            @(negedge clk);
            #5;
            cyc++;
            if (hwInt[irqBit]) begin
                edges = cyc;
            end
        end
        if (edges == 0) begin
            errorCount++;
            $display("Timeout: interrupt bit %0d did not rise within %0d cycles", irqBit, limit);
        end
    endtask

    // Spare lines stay low and the external line tracks extInt
    always @(posedge clk) begin
        checkInt("hwInt[5:2]", {3'b000, extInt, 2'b00}, hwInt & 6'b111100);
    end

    initial begin
        wordT   a;
        wordT   d;
        wordT   r;
        wordT   p;
        byteEnT be;
        int     edges;
        int     pulses;
        int     lastPulse;
        logic   prevHigh;
        clk        = 1'b0;
        arstN      = 1'b0;
        addr       = '0;
        wData      = '0;
        we         = '0;
        extInt     = 1'b0;
        lcgState   = 32'he7149390;
        errorCount = 0;
        checkCount = 0;
        repeat (16) @(negedge clk);
        arstN = 1'b1;
        #5;
        checkInt("hwInt", '0, hwInt);
        for (int i = 0; i < 3; i++) begin
            readCheck(T0_BASE + 4 * i, '0);
            readCheck(T1_BASE + 4 * i, '0);
        end
        // Fill pattern built from the whole byte address
        for (int i = 0; i < `DATA_WORDS; i++) begin
            a = i * 4;
            d = (a * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
            writeWord(a, d, 4'hF);
            shadow[i] = d;
        end
        for (int i = 0; i < 200; i++) begin
            r = nextRand();
            a = {20'd0, r[11:2], 2'b00};
            d = nextRand();
            r = nextRand();
            be = r[31:28];
            writeWord(a, d, be);
            shadow[a[11:2]] = mergeLanes(shadow[a[11:2]], d, be);
            r = nextRand();
            readCheck({20'd0, r[11:2], 2'b00}, expectedRead({20'd0, r[11:2], 2'b00}));
        end
        // Stray writes must not reach the aliased memory word
        for (int i = 0; i < 40; i++) begin
            r = nextRand();
            a = (i % 2 == 0) ? 32'h1000 + (r % 32'h6F00) : (r | 32'h0001_0000);
            a = a & ~32'h3;
            writeWord(a, nextRand(), 4'hF);
            readCheck(a, '0);
            readCheck(a & 32'hFFC, expectedRead(a & 32'hFFC));
        end
        readCheck(T0_BASE + 12, '0);
        readCheck(T1_BASE + 12, '0);
        for (int i = 0; i < 8; i++) begin
            r = nextRand();
            readCheck(`PERIPH_BASE + 32'h20 + ((r % 32'hE0) & ~32'h3), '0);
        end
        writeWord(T0_BASE + 4, 32'h0000_0040, 4'hF);
        writeWord(T0_BASE + 4, 32'hDEAD_BEEF, 4'h7);
        readCheck(T0_BASE + 4, 32'h0000_0040);
        writeWord(T0_BASE, 32'h0000_000F, 4'h3);
        readCheck(T0_BASE, '0);
        // One-shot on timer 0
        r = nextRand();
        p = (r % 6) + 2;
        writeWord(T0_BASE + 4, p, 4'hF);
        writeWord(T0_BASE, ctrlWord(1'b1, oneShot, 1'b1), 4'hF);
        waitIrq(INT_TIMER0, 64, edges);
        checkWord("timer0 irq edge", p + 1, edges);
        readCheck(T0_BASE, ctrlWord(1'b0, oneShot, 1'b1));
        readCheck(T0_BASE + 8, '0);
        repeat (4) @(negedge clk);
        #5;
        checkInt("hwInt", 6'b000001, hwInt & 6'b000011);
        writeWord(T0_BASE, '0, 4'hF);
        #5;
        checkInt("hwInt", '0, hwInt & 6'b000011);
        // Three auto-reload pulses on timer 1
        r = nextRand();
        p = (r % 5) + 3;
        writeWord(T1_BASE + 4, p, 4'hF);
        writeWord(T1_BASE, ctrlWord(1'b1, autoReload, 1'b1), 4'hF);
        addr      = T1_BASE + 8;
        pulses    = 0;
        lastPulse = 0;
        prevHigh  = 1'b0;
        for (int cyc = 1; cyc <= 4 * (p + 1) + 8 && pulses < 3; cyc++) begin
            @(negedge clk);
            #5;
            if (rData > p) begin
                errorCount++;
                $display("Fail rData count 0x%08h above preset 0x%08h at %0t",
                         rData, p, $time);
            end
            if (prevHigh) begin
                checkInt("hwInt[1] after pulse", '0, hwInt & 6'b000010);
            end else if (hwInt[INT_TIMER1]) begin
                pulses++;
                checkWord("timer1 irq edge", (pulses == 1) ? p + 1 : lastPulse + p + 1, cyc);
                lastPulse = cyc;
            end
            prevHigh = hwInt[INT_TIMER1];
        end
        if (pulses < 3) begin
            errorCount++;
            $display("Timeout: timer 1 gave only %0d of 3 pulses", pulses);
        end
        writeWord(T1_BASE, ctrlWord(1'b1, autoReload, 1'b0), 4'hF);
        repeat (3 * (p + 1)) begin
            @(negedge clk);
            #5;
            checkInt("hwInt", '0, hwInt & 6'b000011);
        end
        writeWord(T1_BASE, '0, 4'hF);
        @(negedge clk);
        extInt = 1'b1;
        #5;
        checkInt("hwInt", 6'b000100, hwInt);
        @(negedge clk);
        extInt = 1'b0;
        #5;
        checkInt("hwInt", '0, hwInt);
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: busSubsystem.f
+incdir+hw
hw/busPkg.sv
hw/timerPkg.sv
hw/northBridge.sv
hw/southBridge.sv
hw/dataMemory.sv
hw/intervalTimer.sv
hw/busSubsystem.sv
bench/busSubsystemTb.sv

// File: hw/addrMap_macros.svh
// Address map constants; the peripheral window is 256 bytes, timer slots are 16 bytes apart
`ifndef ADDR_MAP_MACROS_SVH
`define ADDR_MAP_MACROS_SVH

// Data memory range, byte addresses
`define DATA_START   32'h0000_0000
`define DATA_END     32'h0000_0FFF
`define DATA_WORDS   1024

// Peripheral window
`define PERIPH_BASE  32'h0000_7F00
`define PERIPH_END   32'h0000_7FFF

// Timer slot offsets inside the window
`define TIMER0_OFFSET 8'h00
`define TIMER1_OFFSET 8'h10

// Word index of each register inside a timer slot
`define REG_CTRL     2'd0
`define REG_PRESET   2'd1
`define REG_COUNT    2'd2

`endif

// File: hw/busPkg.sv
// Data-bus types shared by the bridges, the memory and the timers; one bus master only
package busPkg;

    // Bus word, used for both addresses and data
    typedef logic [31:0] wordT;

    // Write enable per byte lane, lane 0 is the low byte
    typedef logic [3:0] byteEnT;

    // Interrupt lines 7 down to 2 of the processor
    typedef logic [5:0] hwIntT;

    // Bit positions in hwIntT
    localparam int INT_TIMER0 = 0;
    localparam int INT_TIMER1 = 1;
    localparam int INT_EXT    = 2;

    // Upper three lines have no source yet
    localparam int INT_SPARE_LO = 3;

endpackage

// File: hw/busSubsystem.sv
// Data bus top; reads are combinational, writes land on the next rising clk edge
module busSubsystem import busPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  wordT   addr,
    input  wordT   wData,
    input  byteEnT we,
    input  logic   extInt,
    output wordT   rData,
    output hwIntT  hwInt
);

    // Memory link
    wordT       dmAddr;
    wordT       dmWData;
    byteEnT     dmWe;
    wordT       dmRData;

    // South bridge link
    wordT       sbAddr;
    wordT       sbWData;
    logic       sbWe;
    wordT       sbRData;

    // Timer links
    logic [1:0] t0RegIdx;
    logic [1:0] t1RegIdx;
    wordT       t0WData;
    wordT       t1WData;
    logic       t0We;
    logic       t1We;
    wordT       t0RData;
    wordT       t1RData;
    logic       t0Irq;
    logic       t1Irq;

    northBridge nb (
        .addr(addr), .wData(wData), .we(we), .rData(rData),
        .dmAddr(dmAddr), .dmWData(dmWData), .dmWe(dmWe), .dmRData(dmRData),
        .sbAddr(sbAddr), .sbWData(sbWData), .sbWe(sbWe), .sbRData(sbRData)
    );

    southBridge sb (
        .sbAddr(sbAddr), .sbWData(sbWData), .sbWe(sbWe), .sbRData(sbRData),
        .extInt(extInt), .hwInt(hwInt),
        .t0RegIdx(t0RegIdx), .t0WData(t0WData), .t0We(t0We),
        .t0RData(t0RData), .t0Irq(t0Irq),
        .t1RegIdx(t1RegIdx), .t1WData(t1WData), .t1We(t1We),
        .t1RData(t1RData), .t1Irq(t1Irq)
    );

    dataMemory dm (
        .clk(clk), .addr(dmAddr), .wData(dmWData), .we(dmWe), .rData(dmRData)
    );

    intervalTimer timer0 (
        .clk(clk), .arstN(arstN), .regIdx(t0RegIdx), .wData(t0WData),
        .we(t0We), .rData(t0RData), .irq(t0Irq)
    );

    intervalTimer timer1 (
        .clk(clk), .arstN(arstN), .regIdx(t1RegIdx), .wData(t1WData),
        .we(t1We), .rData(t1RData), .irq(t1Irq)
    );

endmodule

// File: hw/dataMemory.sv
// Word RAM with no reset; address bits above the memory size and bits 1:0 are ignored
`include "addrMap_macros.svh"

module dataMemory import busPkg::*; (
    input  logic   clk,
    input  wordT   addr,
    input  wordT   wData,
    input  byteEnT we,
    output wordT   rData
);

    localparam int IDX_BITS = $clog2(`DATA_WORDS);

    wordT                mem [`DATA_WORDS];
    logic [IDX_BITS-1:0] wordIdx;

    // Byte address to word index
    assign wordIdx = addr[IDX_BITS+1:2];

    // Lane-wise write
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (we[lane]) begin
                mem[wordIdx][lane*8 +: 8] <= wData[lane*8 +: 8];
            end
        end
    end

    // Asynchronous read
    assign rData = mem[wordIdx];

endmodule

// File: hw/intervalTimer.sv
// Full-word writes only; count and index 3 are read-only; auto-reload at preset 0 holds irq high
`include "addrMap_macros.svh"

module intervalTimer import busPkg::*, timerPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic [1:0] regIdx,
    input  wordT       wData,
    input  logic       we,
    output wordT       rData,
    output logic       irq
);

    timerCtrlU ctrl;
    wordT      preset;
    wordT      count;
    logic      ctrlWr;
    logic      presetWr;

    assign ctrlWr   = we && (regIdx == `REG_CTRL);
    assign presetWr = we && (regIdx == `REG_PRESET);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrl.raw <= '0;
            preset   <= '0;
            count    <= '0;
            irq      <= 1'b0;
        end else begin
            // Auto-reload irq lasts one cycle
            if (ctrl.f.mode == autoReload) begin
                irq <= 1'b0;
            end

            if (ctrlWr) begin
                ctrl.raw <= wData;
                irq      <= 1'b0;
            end else if (presetWr) begin
                // Preset also restarts the count
                preset <= wData;
                count  <= wData;
            end else if (ctrl.f.enable) begin
                if (count != '0) begin
                    count <= count - 1'b1;
                end else if (ctrl.f.mode == autoReload) begin
                    count <= preset;
                    if (ctrl.f.intMask) begin
                        irq <= 1'b1;
                    end
                end else begin
                    // One-shot done and irq held until the next ctrl write
                    ctrl.f.enable <= 1'b0;
                    if (ctrl.f.intMask) begin
                        irq <= 1'b1;
                    end
                end
            end
        end
    end

    // Register readback
    always_comb begin
        case (regIdx)
            `REG_CTRL:   rData = ctrl.raw & CTRL_MASK;
            `REG_PRESET: rData = preset;
            `REG_COUNT:  rData = count;
            default:     rData = '0;
        endcase
    end

endmodule

// File: hw/northBridge.sv
// Combinational decode only; peripheral writes need all four lanes, partial writes are dropped
`include "addrMap_macros.svh"

module northBridge import busPkg::*; (
    // Processor side
    input  wordT   addr,
    input  wordT   wData,
    input  byteEnT we,
    output wordT   rData,

    // Data memory side
    output wordT   dmAddr,
    output wordT   dmWData,
    output byteEnT dmWe,
    input  wordT   dmRData,

    // South bridge side
    output wordT   sbAddr,
    output wordT   sbWData,
    output logic   sbWe,
    input  wordT   sbRData
);

    logic inData;
    logic inPeriph;

    // Region decode
    assign inData   = (addr >= `DATA_START) && (addr <= `DATA_END);
    assign inPeriph = (addr >= `PERIPH_BASE) && (addr <= `PERIPH_END);

    // Memory gets every lane the processor asks for, but only in range
    assign dmAddr  = addr;
    assign dmWData = wData;
    assign dmWe    = inData ? we : '0;

    // Peripherals are word registers
    assign sbAddr  = addr;
    assign sbWData = wData;
    assign sbWe    = inPeriph && (&we);

    // Read mux, zero when nothing answers
    always_comb begin
        if (inData) begin
            rData = dmRData;
        end else if (inPeriph) begin
            rData = sbRData;
        end else begin
            rData = '0;
        end
    end

endmodule

// File: hw/southBridge.sv
// Combinational; only address bits 7:2 are decoded and the north bridge qualifies the window
`include "addrMap_macros.svh"

module southBridge import busPkg::*; (
    // North bridge side
    input  wordT        sbAddr,
    input  wordT        sbWData,
    input  logic        sbWe,
    output wordT        sbRData,

    // Interrupts toward the processor
    input  logic        extInt,
    output hwIntT       hwInt,

    // Timer 0
    output logic [1:0]  t0RegIdx,
    output wordT        t0WData,
    output logic        t0We,
    input  wordT        t0RData,
    input  logic        t0Irq,

    // Timer 1
    output logic [1:0]  t1RegIdx,
    output wordT        t1WData,
    output logic        t1We,
    input  wordT        t1RData,
    input  logic        t1Irq
);

    localparam logic [7:0] T0_OFF = `TIMER0_OFFSET;
    localparam logic [7:0] T1_OFF = `TIMER1_OFFSET;

    logic [7:0] offset;
    logic       sel0;
    logic       sel1;

    // Slot select on the upper nibble of the window offset
    assign offset = sbAddr[7:0];
    assign sel0   = (offset[7:4] == T0_OFF[7:4]);
    assign sel1   = (offset[7:4] == T1_OFF[7:4]);

    // Register word index inside the slot
    assign t0RegIdx = offset[3:2];
    assign t1RegIdx = offset[3:2];

    assign t0WData = sbWData;
    assign t1WData = sbWData;
    assign t0We    = sbWe && sel0;
    assign t1We    = sbWe && sel1;

    // Gaps in the window read as zero
    assign sbRData = sel0 ? t0RData :
                     sel1 ? t1RData :
                     '0;

    always_comb begin
        hwInt[INT_TIMER0] = t0Irq;
        hwInt[INT_TIMER1] = t1Irq;
        hwInt[INT_EXT]    = extInt;
        // Spare lines stay low
        hwInt[5:INT_SPARE_LO] = '0;
    end

endmodule

// File: hw/timerPkg.sv
// Timer control-word layout; mode codes 2 and 3 behave as one-shot
package timerPkg;

    // Count mode
    typedef enum logic [1:0] {
        oneShot    = 2'b00,
        autoReload = 2'b01
    } timerModeE;

    // Field view of the control word
    typedef struct packed {
        logic [27:0] rsvd;
        logic        intMask;
        timerModeE   mode;
        logic        enable;
    } timerCtrlFieldsT;

    // Same word seen raw from the bus or as fields by the counter
    typedef union packed {
        logic [31:0]     raw;
        timerCtrlFieldsT f;
    } timerCtrlU;

    // Implemented bits of the control word, the rest read as zero
    localparam logic [31:0] CTRL_MASK = 32'h0000_000F;

endpackage
